/* rtl/cart_settings.svh */
// Fixed constants for the cartridge loader
// Stream addresses count bytes and include the copier header
// Status bit positions must match the menu layout on the host

`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ====================
// Cartridge header
// ====================
`define CART_HDR_SKIP      25'h000200
`define LOROM_SIZE_ADDR    (25'h007FD6 + `CART_HDR_SKIP)
`define HIROM_SIZE_ADDR    (25'h00FFD6 + `CART_HDR_SKIP)
`define EXHIROM_SIZE_ADDR  (25'h40FFD6 + `CART_HDR_SKIP)
// RAM size word follows the ROM size word
`define RAM_SIZE_OFFSET    25'd2

`define DEFAULT_ROM_SIZE   4'd12
`define DEFAULT_RAM_SIZE   4'd0

// ====================
// Streams and storage
// ====================
`define CHEAT_INDEX        8'hFF
`define SECTOR_BITS        9

// ====================
// Status word layout
// ====================
`define ST_RESET           0
`define ST_HDR_MODE_LO     1
`define ST_HDR_MODE_HI     3
`define ST_TURBO           4
`define ST_LOAD            12
`define ST_SAVE            13
`define ST_REGION_LO       14
`define ST_REGION_HI       15
`define ST_AUTOSAVE        23
`define ST_CHEAT_EN        24

`endif

/* rtl/cart_pkg.sv */
// Shared types of the cartridge loader
// Widths follow the host download interface

`default_nettype none

package cart_pkg;

	// Download stream
	typedef logic [24:0] io_addr_t;
	typedef logic [15:0] io_word_t;

	// Header results
	typedef logic [23:0] addr_mask_t;
	typedef logic [7:0]  rom_type_t;
	// Memory holds 1024 << size_code bytes
	typedef logic [3:0]  size_code_t;

	// {flags, address, compare, replace}, 32 bits each
	typedef logic [127:0] cheat_code_t;

	typedef logic [15:0] lba_t;
	typedef logic [31:0] status_t;

	// Header location, from the menu
	typedef enum logic [2:0] {
		auto,
		no_header,
		lorom,
		hirom,
		exhirom
	} header_mode_e;

	// Backup RAM sequencer
	typedef enum logic {
		idle,
		transfer
	} bk_state_e;

endpackage

`default_nettype wire

/* rtl/cart_option_regs.sv */
// Holds the menu status word written by the host
// load_req and save_req pulse for one cycle on a rising bit between writes

`timescale 1ns/10ps
`default_nettype none

`include "cart_settings.svh"

module cart_option_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    opt_wr,
	input  cart_pkg::status_t       opt_data,
	output cart_pkg::header_mode_e  header_mode,
	output logic [1:0]              region_sel,
	output logic                    cheats_en,
	output logic                    autosave,
	output logic                    load_req,
	output logic                    save_req,
	output logic                    soft_reset
);

	import cart_pkg::*;

	status_t status_q;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			status_q <= '0;
			load_req <= 1'b0;
			save_req <= 1'b0;
		end else begin
			load_req <= 1'b0;
			save_req <= 1'b0;
			if (opt_wr) begin
				status_q <= opt_data;
				// Edges against the previously written word
				load_req <= opt_data[`ST_LOAD] & ~status_q[`ST_LOAD];
				save_req <= opt_data[`ST_SAVE] & ~status_q[`ST_SAVE];
			end
		end
	end

	// Field decode
	assign header_mode = header_mode_e'(status_q[`ST_HDR_MODE_HI:`ST_HDR_MODE_LO]);
	assign region_sel  = status_q[`ST_REGION_HI:`ST_REGION_LO];
	assign cheats_en   = status_q[`ST_CHEAT_EN];
	assign autosave    = status_q[`ST_AUTOSAVE];
	assign soft_reset  = status_q[`ST_RESET];

endmodule

`default_nettype wire

/* rtl/rom_header_detect.sv */
// Extracts ROM type, memory sizes and region from the cartridge stream
// Masks lag the size registers by one cycle
// Header mode codes above exhirom behave like auto for the type only

`timescale 1ns/10ps
`default_nettype none

`include "cart_settings.svh"

module rom_header_detect (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic                    ioctl_wr,
	input  cart_pkg::io_addr_t      ioctl_addr,
	input  cart_pkg::io_word_t      ioctl_dout,
	input  cart_pkg::header_mode_e  header_mode,
	input  logic [1:0]              region_sel,
	output cart_pkg::rom_type_t     rom_type,
	output cart_pkg::addr_mask_t    rom_mask,
	output cart_pkg::addr_mask_t    ram_mask,
	output logic                    pal
);

	import cart_pkg::*;

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;
	logic       has_layout;
	io_addr_t   size_addr;

	function automatic addr_mask_t mask_of(input size_code_t sz);
		mask_of = (24'd1024 << sz) - 24'd1;
	endfunction

	// Where the forced layouts keep their size words
	always_comb begin
		has_layout = 1'b1;
		case (header_mode)
			lorom:   size_addr = `LOROM_SIZE_ADDR;
			hirom:   size_addr = `HIROM_SIZE_ADDR;
			exhirom: size_addr = `EXHIROM_SIZE_ADDR;
			default: begin
				size_addr  = '0;
				has_layout = 1'b0;
			end
		endcase
	end

	// ====================
	// Header capture
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= `DEFAULT_ROM_SIZE;
			ram_size   <= `DEFAULT_RAM_SIZE;
			rom_type   <= '0;
			rom_region <= 1'b0;
		end else if (cart_download && ioctl_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= `DEFAULT_ROM_SIZE;
				ram_size <= `DEFAULT_RAM_SIZE;
				// Packed sizes only in auto mode
				if (header_mode == auto && ioctl_dout[7:0] != 8'h00)
					{ram_size, rom_size} <= ioctl_dout[7:0];
				case (header_mode)
					no_header, lorom: rom_type <= 8'd0;
					hirom:            rom_type <= 8'd1;
					exhirom:          rom_type <= 8'd2;
					default:          rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == 25'd2)
				rom_region <= ioctl_dout[8];
			if (has_layout && ioctl_addr == size_addr)
				rom_size <= ioctl_dout[11:8];
			if (has_layout && ioctl_addr == size_addr + `RAM_SIZE_OFFSET)
				ram_size <= ioctl_dout[3:0];
		end
	end

	// Masks and region
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_mask <= mask_of(`DEFAULT_ROM_SIZE);
			ram_mask <= (`DEFAULT_RAM_SIZE == 4'd0) ? '0 : mask_of(`DEFAULT_RAM_SIZE);
			pal      <= 1'b0;
		end else begin
			rom_mask <= mask_of(rom_size);
			ram_mask <= (ram_size == '0) ? '0 : mask_of(ram_size);
			if (!cart_download)
				pal <= (region_sel == 2'b00) ? rom_region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

/* rtl/cheat_code_loader.sv */
// Builds one cheat record from eight 16-bit stream words
// Only even offsets 0 to 14 are used, the valid pulse follows offset 14

`timescale 1ns/10ps
`default_nettype none

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  code_download,
	input  logic                  ioctl_wr,
	input  cart_pkg::io_addr_t    ioctl_addr,
	input  cart_pkg::io_word_t    ioctl_dout,
	output cart_pkg::cheat_code_t gg_code,
	output logic                  gg_code_valid
);

	// Record fields, low word first
	always_ff @(posedge clk_sys) begin
		if (code_download && ioctl_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code[111:96]  <= ioctl_dout;
				4'd2:  gg_code[127:112] <= ioctl_dout;
				4'd4:  gg_code[79:64]   <= ioctl_dout;
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout;
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout;
				4'd14: gg_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word completes the record
	always_ff @(posedge clk_sys) begin
		if (!reset)
			gg_code_valid <= 1'b0;
		else
			gg_code_valid <= code_download & ioctl_wr & (ioctl_addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

/* rtl/backup_sync.sv */
// Moves backup RAM between the core and the block device, one sector per request
// The sector count comes from ram_mask, which must be stable during a transfer
// Requests are levels, the device answers with an sd_ack pulse of any length

`timescale 1ns/10ps
`default_nettype none

`include "cart_settings.svh"

module backup_sync (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 cart_download,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic [31:0]          img_size,
	input  cart_pkg::addr_mask_t ram_mask,
	input  logic                 bsram_write,
	input  logic                 osd_status,
	input  logic                 autosave,
	input  logic                 load_req,
	input  logic                 save_req,
	input  logic                 sd_ack,
	output cart_pkg::lba_t       sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_loading,
	output logic                 bk_busy,
	output logic                 bk_pending
);

	import cart_pkg::*;

	bk_state_e state;
	logic      bk_ena;
	logic      old_download;
	logic      old_ack;
	logic      start_load;
	logic      start_save;
	lba_t      last_lba;

	assign last_lba = lba_t'(ram_mask >> `SECTOR_BITS);
	assign bk_busy  = (state == transfer);

	// Download end with an image present loads the save
	assign start_load = bk_ena & (load_req | (old_download & ~cart_download & |img_size));
	assign start_save = bk_ena & (save_req | (autosave & osd_status & bk_pending));

	// ====================
	// Enable and dirty flag
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
			old_download <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download)
				bk_ena <= 1'b0;
			// Save image is mounted while the cartridge still downloads
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			if (bk_ena && !osd_status && bsram_write)
				bk_pending <= 1'b1;
			else if (state == transfer)
				bk_pending <= 1'b0;
		end
	end

	// ====================
	// Sector sequencer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= idle;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				idle: begin
					if (start_load || start_save) begin
						state      <= transfer;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				transfer: begin
					// Next sector only after the device releases sd_ack
					if (old_ack && !sd_ack) begin
						if (sd_lba >= last_lba) begin
							state      <= idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 16'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/cart_loader_top.sv */
// Cartridge loading side of the console top level
// Download index CHEAT_INDEX carries cheats, every other index a cartridge
// The download stream has no back-pressure

`timescale 1ns/10ps
`default_nettype none

`include "cart_settings.svh"

module cart_loader_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  cart_pkg::io_addr_t    ioctl_addr,
	input  cart_pkg::io_word_t    ioctl_dout,
	input  logic                  opt_wr,
	input  cart_pkg::status_t     opt_data,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [31:0]           img_size,
	input  logic                  bsram_write,
	input  logic                  osd_status,
	input  logic                  sd_ack,
	output cart_pkg::rom_type_t   rom_type,
	output cart_pkg::addr_mask_t  rom_mask,
	output cart_pkg::addr_mask_t  ram_mask,
	output logic                  pal,
	output cart_pkg::cheat_code_t gg_code,
	output logic                  gg_code_valid,
	output logic                  gg_reset,
	output cart_pkg::lba_t        sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  bk_loading,
	output logic                  led_user,
	output logic                  core_reset
);

	import cart_pkg::*;

	logic         cart_download;
	logic         code_download;
	header_mode_e header_mode;
	logic [1:0]   region_sel;
	logic         autosave;
	logic         load_req;
	logic         save_req;
	logic         soft_reset;
	logic         bk_pending;

	// ====================
	// Stream decode
	// ====================
	assign code_download = ioctl_download & (ioctl_index == `CHEAT_INDEX);
	assign cart_download = ioctl_download & (ioctl_index != `CHEAT_INDEX);

	// Cheat list restarts with each cartridge or cheat file
	assign gg_reset   = cart_download | (code_download & ioctl_wr & (ioctl_addr == '0));
	assign led_user   = cart_download | (autosave & bk_pending);
	assign core_reset = soft_reset | cart_download | bk_loading;

	cart_option_regs u_opts (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.opt_wr      (opt_wr),
		.opt_data    (opt_data),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.cheats_en   (),
		.autosave    (autosave),
		.load_req    (load_req),
		.save_req    (save_req),
		.soft_reset  (soft_reset)
	);

	rom_header_detect u_hdr (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	cheat_code_loader u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_code_valid (gg_code_valid)
	);

	backup_sync u_bk (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.ram_mask      (ram_mask),
		.bsram_write   (bsram_write),
		.osd_status    (osd_status),
		.autosave      (autosave),
		.load_req      (load_req),
		.save_req      (save_req),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_loading    (bk_loading),
		.bk_busy       (),
		.bk_pending    (bk_pending)
	);

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock and reset source
// 10 ns clock, reset held low for the first two rising edges

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/cart_loader_asserts.sv */
// Protocol checks bound into the cartridge loader top level
// Only active while reset is released

`timescale 1ns/10ps
`default_nettype none

module cart_loader_asserts (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic gg_code_valid
);

	// A new request must wait for the device to release sd_ack
	req_rise_without_ack: assert property (
		@(posedge clk_sys) disable iff (!reset)
		$rose(sd_rd | sd_wr) |-> !sd_ack
	) else $error("sector request raised while sd_ack is high");

	// Cheat record strobe is a single cycle
	cheat_valid_one_cycle: assert property (
		@(posedge clk_sys) disable iff (!reset)
		gg_code_valid |=> !gg_code_valid
	) else $error("gg_code_valid held for more than one cycle");

endmodule

bind cart_loader_top cart_loader_asserts i_asserts (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.sd_rd         (sd_rd),
	.sd_wr         (sd_wr),
	.sd_ack        (sd_ack),
	.gg_code_valid (gg_code_valid)
);

`default_nettype wire

/* dv/cart_loader_tb.sv */
// Vector-driven testbench for the cartridge loader
// Vectors come from dv/cart_loader_vectors.txt with three hex words per line
// Includes a block-device model with random acknowledge delays

`timescale 1ns/10ps
`default_nettype none

`include "cart_settings.svh"

module cart_loader_tb;

	import cart_pkg::*;

	localparam int MAX_LINES       = 64;
	localparam int CYCLES_PER_LINE = 200;
	localparam int CLK_PERIOD      = 10;

	logic         clk_sys;
	logic         reset;
	logic         ioctl_download;
	logic [7:0]   ioctl_index;
	logic         ioctl_wr;
	io_addr_t     ioctl_addr;
	io_word_t     ioctl_dout;
	logic         opt_wr;
	status_t      opt_data;
	logic         img_mounted;
	logic         img_readonly;
	logic [31:0]  img_size;
	logic         bsram_write;
	logic         osd_status;
	logic         sd_ack;
	rom_type_t    rom_type;
	addr_mask_t   rom_mask;
	addr_mask_t   ram_mask;
	logic         pal;
	cheat_code_t  gg_code;
	logic         gg_code_valid;
	logic         gg_reset;
	lba_t         sd_lba;
	logic         sd_rd;
	logic         sd_wr;
	logic         bk_loading;
	logic         led_user;
	logic         core_reset;

	logic [31:0]  vec [0:3*MAX_LINES-1];
	int           n_lines;
	int           errors;
	int           valid_cnt;
	int           greset_cnt;
	logic [31:0]  lcg_state;
	lba_t         rec_lba[$];
	logic         rec_dir[$];

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	cart_loader_top i_dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.opt_wr         (opt_wr),
		.opt_data       (opt_data),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.bsram_write    (bsram_write),
		.osd_status     (osd_status),
		.sd_ack         (sd_ack),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal),
		.gg_code        (gg_code),
		.gg_code_valid  (gg_code_valid),
		.gg_reset       (gg_reset),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.bk_loading     (bk_loading),
		.led_user       (led_user),
		.core_reset     (core_reset)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic fail_now();
		errors++;
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_signal(input logic [31:0] id, input logic [31:0] exp);
		case (id)
			0:  check_value("rom_type", 32'(rom_type), exp);
			1:  check_value("rom_mask", 32'(rom_mask), exp);
			2:  check_value("ram_mask", 32'(ram_mask), exp);
			3:  check_value("pal", 32'(pal), exp);
			4:  check_value("gg_code flags", gg_code[127:96], exp);
			5:  check_value("gg_code address", gg_code[95:64], exp);
			6:  check_value("gg_code compare", gg_code[63:32], exp);
			7:  check_value("gg_code replace", gg_code[31:0], exp);
			8:  check_value("gg_code_valid pulses", 32'(valid_cnt), exp);
			9:  check_value("led_user", 32'(led_user), exp);
			10: check_value("core_reset", 32'(core_reset), exp);
			11: check_value("gg_reset on cheat writes", 32'(greset_cnt), exp);
			default: begin
				$display("Unknown signal id %0d in a check vector", id);
				fail_now();
			end
		endcase
	endtask

	// Sectors must run 0 up to count-1 in one direction
	task automatic expect_transfer(input logic dir, input int count);
		while (rec_lba.size() == 0)
			step();
		// Loads hold bk_loading for the whole transfer
		check_value("bk_loading", 32'(bk_loading), 32'(!dir));
		while (rec_lba.size() < count)
			step();
		repeat (10) step();
		check_value("sector count", 32'(rec_lba.size()), 32'(count));
		check_value("bk_loading", 32'(bk_loading), 32'd0);
		check_value("sd_rd", 32'(sd_rd), 32'd0);
		check_value("sd_wr", 32'(sd_wr), 32'd0);
		for (int i = 0; i < count; i++) begin
			check_value("sd_lba", 32'(rec_lba[i]), 32'(i));
			check_value("sd_wr direction", 32'(rec_dir[i]), 32'(dir));
		end
		rec_lba.delete();
		rec_dir.delete();
	endtask

	// ====================
	// Block device model
	// ====================
	initial begin : block_device
		int wait_cycles;
		int ack_cycles;
		sd_ack    = 1'b0;
		lcg_state = 32'd26;
		forever begin
			step();
			if ((sd_rd || sd_wr) && !sd_ack) begin
				rec_lba.push_back(sd_lba);
				rec_dir.push_back(sd_wr);
				lcg_state   = lcg_next(lcg_state);
				wait_cycles = 1 + int'(lcg_state[17:16]);
				ack_cycles  = 1 + int'(lcg_state[20]);
				repeat (wait_cycles) step();
				sd_ack = 1'b1;
				repeat (ack_cycles) step();
				sd_ack = 1'b0;
			end
		end
	end

	// Mid-cycle monitor
	always @(posedge clk_sys) begin
		#5;
		if (reset) begin
			if (gg_code_valid)
				valid_cnt++;
			if (gg_reset && ioctl_index == `CHEAT_INDEX)
				greset_cnt++;
			if (bk_loading)
				check_value("core_reset", 32'(core_reset), 32'd1);
		end
	end

	// ====================
	// Vector player
	// ====================
	initial begin : run
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] d;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		opt_wr         = 1'b0;
		opt_data       = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bsram_write    = 1'b0;
		osd_status     = 1'b0;
		errors         = 0;
		valid_cnt      = 0;
		greset_cnt     = 0;
		for (int k = 0; k < 3 * MAX_LINES; k++)
			vec[k] = '0;
		$readmemh("dv/cart_loader_vectors.txt", vec);
		n_lines = 0;
		while (n_lines < MAX_LINES && vec[3*n_lines] != 32'd0)
			n_lines++;

		wait (reset === 1'b1);
		step();
		for (int line = 0; line < n_lines; line++) begin
			op = vec[3*line];
			a  = vec[3*line+1];
			d  = vec[3*line+2];
			case (op)
				1: begin
					opt_data = a;
					opt_wr   = 1'b1;
					step();
					opt_wr   = 1'b0;
				end
				2: begin
					ioctl_index    = a[7:0];
					ioctl_download = 1'b1;
					step();
				end
				3: begin
					ioctl_download = 1'b0;
					step();
				end
				4: begin
					ioctl_addr = a[24:0];
					ioctl_dout = d[15:0];
					ioctl_wr   = 1'b1;
					step();
					ioctl_wr   = 1'b0;
				end
				5: begin
					img_readonly = a[0];
					img_size     = d;
					img_mounted  = 1'b1;
					step();
					img_mounted  = 1'b0;
				end
				6: begin
					bsram_write = 1'b1;
					step();
					bsram_write = 1'b0;
				end
				7:  osd_status = a[0];
				8:  check_signal(a, d);
				9:  expect_transfer(a[0], int'(d));
				10: repeat (a) step();
				default: begin
					$display("Unknown vector op %h on line %0d", op, line);
					fail_now();
				end
			endcase
		end

		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin : watchdog
		#1;
		#((n_lines + 1) * CYCLES_PER_LINE * CLK_PERIOD);
		$display("Timeout: vectors did not finish in %0d cycles",
			(n_lines + 1) * CYCLES_PER_LINE);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* dv/cart_loader_vectors.txt */
// Columns (hex): op arg1 arg2
// op 1 status(word) 2 download start(index) 3 download end 4 write(addr data)
// op 5 mount(readonly size) 6 backup write 7 menu(open) 8 check(id value)
// op 9 transfer(dir count) A idle(cycles) 0 end
A 2 0
// Forced hirom, region forced to PAL
1 8006 0
2 0 0
4 0 0
4 101D6 0B00
4 101D8 0001
3 0 0
A 3 0
8 0 1
8 1 1FFFFF
8 2 7FF
8 3 1
// Auto header, writable save image, load after download
1 800000 0
2 1 0
4 0 213A
4 2 0100
A 3 0
8 0 21
8 1 FFFFF
8 2 1FFF
5 0 2000
3 0 0
9 0 10
8 3 1
8 A 0
// Dirty backup RAM, then save from the menu
7 0 0
6 0 0
A 2 0
8 9 1
1 802000 0
9 1 10
8 9 0
// Cheat record
2 FF 0
4 0 0001
4 2 8000
4 4 5678
4 6 1234
4 8 00AA
4 A 0000
4 C 00BB
4 E 0000
3 0 0
A 3 0
8 4 80000001
8 5 12345678
8 6 000000AA
8 7 000000BB
8 8 1
8 B 1
0 0 0

/* compile.f */
+incdir+rtl
rtl/cart_pkg.sv
rtl/cart_option_regs.sv
rtl/rom_header_detect.sv
rtl/cheat_code_loader.sv
rtl/backup_sync.sv
rtl/cart_loader_top.sv
dv/tb_clock_gen.sv
dv/cart_loader_asserts.sv
dv/cart_loader_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cart_loader_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
